/* dcache_asserts.sv */
////////////////////////////////////////////////////////////
// Protocol checks on the cache ports, bound to dcache_top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_asserts (
  input wire                              clk,
  input wire                              rst,
  input wire dcache_bus_pkg::dc_cpu_req_t cpu_i,
  input wire                              cpu_ack_o,
  input wire dcache_bus_pkg::dc_refill_t  refill_i,
  input wire                              refill_req_o,
  input wire [`DC_ADDR_WIDTH-1:0]         refill_adr_o,
  input wire dcache_bus_pkg::dc_spr_t     spr_i,
  input wire                              spr_ack_o
);

  localparam int WORDS = 1 << `DC_WORD_WIDTH;

  int   fail_cnt = 0;
  int   strobe_cnt;
  logic last_strobe;
  logic spr_decoded;

  // Refill words seen so far in this request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      strobe_cnt <= 0;
    end else if (!refill_req_o) begin
      strobe_cnt <= 0;
    end else if (refill_i.we) begin
      strobe_cnt <= strobe_cnt + 1;
    end
  end

  assign last_strobe = refill_req_o && refill_i.we && (strobe_cnt == WORDS - 1);
  assign spr_decoded = spr_i.stb && spr_i.we &&
                       ((spr_i.adr == `DC_SPR_DCBFR) || (spr_i.adr == `DC_SPR_DCBIR));

  ack_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o |=> !cpu_ack_o)
    else begin $error("cpu_ack_o high for more than one cycle"); fail_cnt++; end

  ack_with_req: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_o |-> (cpu_i.req && !refill_req_o))
    else begin $error("cpu_ack_o without a request or during refill"); fail_cnt++; end

  // Level held until the last word of the block
  refill_hold: assert property (@(posedge clk) disable iff (rst)
    (refill_req_o && !last_strobe) |=> (refill_req_o && $stable(refill_adr_o)))
    else begin $error("refill_req_o or refill_adr_o changed mid refill"); fail_cnt++; end

  refill_end: assert property (@(posedge clk) disable iff (rst)
    last_strobe |=> !refill_req_o)
    else begin $error("refill_req_o still high after the last word"); fail_cnt++; end

  refill_aligned: assert property (@(posedge clk) disable iff (rst)
    refill_req_o |-> (refill_adr_o[`DC_BLOCK_WIDTH-1:0] == '0))
    else begin $error("refill_adr_o not on a block boundary"); fail_cnt++; end

  spr_ack_ok: assert property (@(posedge clk) disable iff (rst)
    spr_ack_o |-> spr_decoded ##1 !spr_ack_o)
    else begin $error("spr_ack_o for a wrong SPR write or longer than a cycle"); fail_cnt++; end

endmodule

bind dcache_top dcache_asserts u_asserts (
  .clk          (clk),
  .rst          (rst),
  .cpu_i        (cpu_i),
  .cpu_ack_o    (cpu_ack_o),
  .refill_i     (refill_i),
  .refill_req_o (refill_req_o),
  .refill_adr_o (refill_adr_o),
  .spr_i        (spr_i),
  .spr_ack_o    (spr_ack_o)
);

`default_nettype wire

/* dcache_bus_pkg.sv */
////////////////////////////////////////////////////////////
// Structs for the buses around the cache: CPU, refill, SPR
////////////////////////////////////////////////////////////

`default_nettype none

`include "dcache_settings.svh"

package dcache_bus_pkg;

  // CPU request, fields held steady until the acknowledge
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`DC_ADDR_WIDTH-1:0] adr;
    logic [`DC_ADDR_WIDTH-1:0] dat;
    logic [3:0]                bsel;
  } dc_cpu_req_t;

  // Refill data, one strobe per word in increasing order
  typedef struct packed {
    logic                      we;
    logic [`DC_ADDR_WIDTH-1:0] dat;
  } dc_refill_t;

  // SPR write port, stb held until acknowledged
  typedef struct packed {
    logic                          stb;
    logic                          we;
    logic [`DC_SPR_ADDR_WIDTH-1:0] adr;
    logic [`DC_ADDR_WIDTH-1:0]     dat;
  } dc_spr_t;

endpackage

`default_nettype wire

/* dcache_ctrl.sv */
////////////////////////////////////////////////////////////
// Cache controller: tag sweep, lookup, write merge, refill
// Owns the data RAM and drives the controller tag write port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
  input  wire                              clk,
  input  wire                              rst,
  input  wire dcache_bus_pkg::dc_cpu_req_t cpu_i,
  output logic                             cpu_ack_o,
  output logic [`DC_ADDR_WIDTH-1:0]        cpu_dat_o,
  input  wire dcache_bus_pkg::dc_refill_t  refill_i,
  output logic                             refill_req_o,
  output logic [`DC_ADDR_WIDTH-1:0]        refill_adr_o,
  input  wire dcache_pkg::dc_tag_entry_t   tag_i,
  output dcache_pkg::dc_set_t              tag_rindex_o,
  output dcache_pkg::dc_tag_wr_t           tag_wr_o
);

  import dcache_pkg::*;

  localparam int RAM_AW = `DC_SET_WIDTH + `DC_WORD_WIDTH;

  typedef enum logic [1:0] {
    RESET,
    IDLE,
    LOOKUP,
    REFILL
  } state_t;

  state_t   state_q;
  state_t   state_d;
  dc_addr_u cpu_adr;
  dc_addr_u base_adr;
  dc_set_t  sweep_q;
  dc_word_t refill_cnt_q;
  logic     hit;
  logic     first_word;
  logic     last_word;

  // Data RAM port signals
  logic                      ram_we;
  logic [RAM_AW-1:0]         ram_raddr;
  logic [RAM_AW-1:0]         ram_waddr;
  logic [`DC_ADDR_WIDTH-1:0] ram_din;
  logic [`DC_ADDR_WIDTH-1:0] ram_dout;
  logic [`DC_ADDR_WIDTH-1:0] merged;

  ////////////////////////////////////////////////////////////
  // Address decode and hit
  ////////////////////////////////////////////////////////////

  // CPU holds the address until ack, no local copy needed
  assign cpu_adr.flat = cpu_i.adr;

  // Block base for the refill bus
  always_comb begin
    base_adr            = cpu_adr;
    base_adr.f.word     = '0;
    base_adr.f.byte_off = '0;
  end

  assign refill_adr_o = base_adr.flat;
  assign tag_rindex_o = cpu_adr.f.set;
  assign hit          = tag_i.valid && (tag_i.tag == cpu_adr.f.tag);

  assign first_word = (refill_cnt_q == '0);
  assign last_word  = (&refill_cnt_q);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    cpu_ack_o = 1'b0;
    case (state_q)
      // One set cleared per cycle, requests wait
      RESET: begin
        if (&sweep_q) begin
          state_d = IDLE;
        end
      end
      // RAM reads start here
      IDLE: begin
        if (cpu_i.req) begin
          state_d = LOOKUP;
        end
      end
      // Writes never allocate, so they always finish here
      LOOKUP: begin
        if (cpu_i.we || hit) begin
          cpu_ack_o = 1'b1;
          state_d   = IDLE;
        end else begin
          state_d = REFILL;
        end
      end
      // Back to IDLE to repeat the lookup, which then hits
      REFILL: begin
        if (refill_i.we && last_word) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q      <= RESET;
      sweep_q      <= '0;
      refill_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RESET) begin
        sweep_q <= sweep_q + 1'b1;
      end
      // Word counter restarts with every lookup
      if (state_q == LOOKUP) begin
        refill_cnt_q <= '0;
      end else if ((state_q == REFILL) && refill_i.we) begin
        refill_cnt_q <= refill_cnt_q + 1'b1;
      end
    end
  end

  assign refill_req_o = (state_q == REFILL);

  ////////////////////////////////////////////////////////////
  // Tag writes
  ////////////////////////////////////////////////////////////

  always_comb begin
    tag_wr_o = '0;
    case (state_q)
      RESET: begin
        tag_wr_o.req = 1'b1;
        tag_wr_o.set = sweep_q;
      end
      REFILL: begin
        // Invalid on the first word, valid with new tag on the last
        if (refill_i.we && (first_word || last_word)) begin
          tag_wr_o.req         = 1'b1;
          tag_wr_o.set         = cpu_adr.f.set;
          tag_wr_o.entry.valid = last_word;
          tag_wr_o.entry.tag   = cpu_adr.f.tag;
        end
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Data RAM
  ////////////////////////////////////////////////////////////

  // Byte merge of the store into the old word
  always_comb begin
    for (int b = 0; b < `DC_ADDR_WIDTH/8; b++) begin
      merged[8*b +: 8] = cpu_i.bsel[b] ? cpu_i.dat[8*b +: 8] : ram_dout[8*b +: 8];
    end
  end

  assign ram_raddr = {cpu_adr.f.set, cpu_adr.f.word};

  always_comb begin
    if (state_q == REFILL) begin
      ram_waddr = {cpu_adr.f.set, refill_cnt_q};
      ram_din   = refill_i.dat;
      ram_we    = refill_i.we;
    end else begin
      ram_waddr = {cpu_adr.f.set, cpu_adr.f.word};
      ram_din   = merged;
      ram_we    = (state_q == LOOKUP) && cpu_i.we && hit;
    end
  end

  dcache_sdpram #(
    .ADDR_W (RAM_AW),
    .DATA_W (`DC_ADDR_WIDTH),
    .BYPASS (1'b0)
  ) u_data_ram (
    .clk     (clk),
    .raddr_i (ram_raddr),
    .waddr_i (ram_waddr),
    .we_i    (ram_we),
    .din_i   (ram_din),
    .dout_o  (ram_dout)
  );

  assign cpu_dat_o = ram_dout;

endmodule

`default_nettype wire

/* dcache_inval.sv */
////////////////////////////////////////////////////////////
// SPR decode for block flush and invalidate
// Requests a tag clear and acknowledges once it is written
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_inval (
  input  wire                          clk,
  input  wire                          rst,
  input  wire dcache_bus_pkg::dc_spr_t spr_i,
  input  wire                          grant_i,
  output dcache_pkg::dc_tag_wr_t       wr_o,
  output logic                         spr_ack_o
);

  import dcache_pkg::*;

  dc_addr_u blk_adr;
  logic     spr_hit;
  logic     acked_q;

  // The data word carries the block address
  assign blk_adr.flat = spr_i.dat;

  // Flush and invalidate do the same thing here, no dirty data
  assign spr_hit = spr_i.stb && spr_i.we &&
                   ((spr_i.adr == `DC_SPR_DCBFR) || (spr_i.adr == `DC_SPR_DCBIR));

  always_comb begin
    wr_o     = '0;
    // Hold off for the cycle after the ack while stb falls
    wr_o.req = spr_hit && !acked_q;
    wr_o.set = blk_adr.f.set;
  end

  // Ack in the cycle the clear goes into the RAM
  assign spr_ack_o = wr_o.req && grant_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acked_q <= 1'b0;
    end else begin
      acked_q <= spr_ack_o;
    end
  end

endmodule

`default_nettype wire

/* dcache_pkg.sv */
////////////////////////////////////////////////////////////
// Types for the cache geometry: address decode and tag entry
// Import where tags or decoded addresses are handled
////////////////////////////////////////////////////////////

`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

  // Address fields
  typedef logic [`DC_TAG_WIDTH-1:0]  dc_tag_t;
  typedef logic [`DC_SET_WIDTH-1:0]  dc_set_t;
  typedef logic [`DC_WORD_WIDTH-1:0] dc_word_t;

  // Field view of one address, msb first
  typedef struct packed {
    dc_tag_t    tag;
    dc_set_t    set;
    dc_word_t   word;
    logic [1:0] byte_off;
  } dc_addr_fields_t;

  // One address word, seen flat or split into its fields
  typedef union packed {
    logic [`DC_ADDR_WIDTH-1:0] flat;
    dc_addr_fields_t           f;
  } dc_addr_u;

  // One tag RAM word
  typedef struct packed {
    logic    valid;
    dc_tag_t tag;
  } dc_tag_entry_t;

  // Write request to the tag RAM from one peer
  typedef struct packed {
    logic          req;
    dc_set_t       set;
    dc_tag_entry_t entry;
  } dc_tag_wr_t;

endpackage

`default_nettype wire

/* dcache_sdpram.sv */
////////////////////////////////////////////////////////////
// Simple dual-port RAM, one write and one registered read
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dcache_sdpram #(
  parameter int ADDR_W = 6,
  parameter int DATA_W = 32,
  parameter bit BYPASS = 1'b0
) (
  input  wire               clk,
  input  wire  [ADDR_W-1:0] raddr_i,
  input  wire  [ADDR_W-1:0] waddr_i,
  input  wire               we_i,
  input  wire  [DATA_W-1:0] din_i,
  output logic [DATA_W-1:0] dout_o
);

  logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
  end

  // Read port, with bypass a colliding write wins
  always_ff @(posedge clk) begin
    if (BYPASS && we_i && (waddr_i == raddr_i)) begin
      dout_o <= din_i;
    end else begin
      dout_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

/* dcache_settings.svh */
////////////////////////////////////////////////////////////
// Cache geometry and SPR addresses for the data cache
// Include in any file that sizes a port or decodes an SPR
////////////////////////////////////////////////////////////

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Geometry
////////////////////////////////////////////////////////////

// Address and data word width
`define DC_ADDR_WIDTH 32

// log2 of the block size in bytes, 16 bytes gives four words
`define DC_BLOCK_WIDTH 4

// log2 of the number of sets
`define DC_SET_WIDTH 6

// Word select inside a block, bytes within a word are dropped
`define DC_WORD_WIDTH (`DC_BLOCK_WIDTH - 2)

// Whatever is left above set index and block offset
`define DC_TAG_WIDTH (`DC_ADDR_WIDTH - `DC_SET_WIDTH - `DC_BLOCK_WIDTH)

////////////////////////////////////////////////////////////
// SPR bus
////////////////////////////////////////////////////////////

`define DC_SPR_ADDR_WIDTH 16

// Block flush and block invalidate, both handled as a clear
`define DC_SPR_DCBFR 16'h3002
`define DC_SPR_DCBIR 16'h3003

`endif

/* dcache_tag_arbiter.sv */
////////////////////////////////////////////////////////////
// Tag RAM with a fixed-priority write port
// Controller always wins, invalidate unit gets the free cycles
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dcache_tag_arbiter (
  input  wire                            clk,
  input  wire                            rst,
  input  wire dcache_pkg::dc_set_t       rindex_i,
  input  wire dcache_pkg::dc_tag_wr_t    ctrl_wr_i,
  input  wire dcache_pkg::dc_tag_wr_t    inval_wr_i,
  output logic                           inval_grant_o,
  output dcache_pkg::dc_tag_entry_t      tag_o
);

  import dcache_pkg::*;

  logic          sweep_done_q;
  logic          tag_we;
  dc_set_t       tag_windex;
  dc_tag_entry_t tag_din;

  // Goes high once the controller has cleared the last set
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sweep_done_q <= 1'b0;
    end else if (ctrl_wr_i.req && (&ctrl_wr_i.set)) begin
      sweep_done_q <= 1'b1;
    end
  end

  // Invalidate only in a cycle the controller leaves free
  assign inval_grant_o = inval_wr_i.req && !ctrl_wr_i.req && sweep_done_q;

  always_comb begin
    if (ctrl_wr_i.req) begin
      tag_windex = ctrl_wr_i.set;
      tag_din    = ctrl_wr_i.entry;
    end else begin
      tag_windex = inval_wr_i.set;
      tag_din    = inval_wr_i.entry;
    end
    tag_we = ctrl_wr_i.req || inval_grant_o;
  end

  // Bypass on, so a lookup started with a clear sees the clear
  dcache_sdpram #(
    .ADDR_W ( 
      $bits(dc_set_t)),
    .DATA_W ($bits(dc_tag_entry_t)),
    .BYPASS (1'b1)
  ) u_tag_ram (
    .clk     (clk),
    .raddr_i (rindex_i),
    .waddr_i (tag_windex),
    .we_i    (tag_we),
    .din_i   (tag_din),
    .dout_o  (tag_o)
  );

endmodule

`default_nettype wire

/* dcache_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the data cache, plays CPU, memory and SPR bus
// Run with the file list, the top module is dcache_tb
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

  import dcache_bus_pkg::*;

  typedef logic [`DC_ADDR_WIDTH-1:0] word_t;

  localparam int    BLK_BYTES = 1 << `DC_BLOCK_WIDTH;
  localparam int    WORDS     = BLK_BYTES / 4;
  localparam int    SETS      = 1 << `DC_SET_WIDTH;
  localparam int    MAX_WAIT  = 25;
  localparam int    N_RANDOM  = 180;
  // About 200 transactions of at most 25 cycles, plus the tag sweep
  localparam int    LIMIT     = 6000;
  localparam word_t SEED      = 32'h1bfb95be;

  logic        clk = 1'b0;
  logic        rst;
  dc_cpu_req_t cpu_req;
  logic        cpu_ack;
  word_t       cpu_dat;
  dc_refill_t  refill_bus = '0;
  logic        refill_req;
  word_t       refill_adr;
  dc_spr_t     spr_bus;
  logic        spr_ack;

  // Memory model, only written words are stored
  word_t mem_q [word_t];
  // Which block each set should hold
  word_t cached_base [SETS];
  logic  cached_valid [SETS];

  int    data_errs;
  int    check_errs;
  int    cycles;
  int    refill_cnt = 0;
  logic  gap_last = 1'b0;
  word_t gap_rng = SEED;

  always #10 clk = ~clk;

  dcache_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .cpu_i        (cpu_req),
    .cpu_ack_o    (cpu_ack),
    .cpu_dat_o    (cpu_dat),
    .refill_i     (refill_bus),
    .refill_req_o (refill_req),
    .refill_adr_o (refill_adr),
    .spr_i        (spr_bus),
    .spr_ack_o    (spr_ack)
  );

  ////////////////////////////////////////////////////////////
  // Models and helpers
  ////////////////////////////////////////////////////////////

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Power-up contents, every address bit matters
  function automatic word_t fill_word(input word_t adr);
    return (adr * 32'h9e3779b9) ^ {adr[15:0], adr[31:16]};
  endfunction

  function automatic word_t model_read(input word_t adr);
    word_t key;
    key = {adr[`DC_ADDR_WIDTH-1:2], 2'b00};
    if (mem_q.exists(key)) begin
      return mem_q[key];
    end
    return fill_word(key);
  endfunction

  // Byte-wise store into the memory model
  task automatic model_write(input word_t adr, input word_t dat, input logic [3:0] bsel);
    word_t w;
    w = model_read(adr);
    for (int b = 0; b < 4; b++) begin
      if (bsel[b]) begin
        w[8*b +: 8] = dat[8*b +: 8];
      end
    end
    mem_q[{adr[`DC_ADDR_WIDTH-1:2], 2'b00}] = w;
  endtask

  function automatic int set_of(input word_t adr);
    return int'(adr[`DC_BLOCK_WIDTH +: `DC_SET_WIDTH]);
  endfunction

  function automatic word_t base_of(input word_t adr);
    return adr & ~word_t'(BLK_BYTES - 1);
  endfunction

  // Two tags over four sets, any word of the block
  function automatic word_t random_addr(input word_t r);
    word_t a;
    a = 32'h0004_0000;
    a[`DC_BLOCK_WIDTH + `DC_SET_WIDTH] = r[16];
    a[`DC_BLOCK_WIDTH +: 2] = r[19:18];
    a[2 +: `DC_WORD_WIDTH] = r[20 +: `DC_WORD_WIDTH];
    return a;
  endfunction

  task automatic check_read_data(input word_t exp);
    assert (cpu_dat == exp) else begin
      $display("Error cpu_dat_o expected %h actual %h", exp, cpu_dat);
      data_errs++;
    end
  endtask

  // Outputs must stay quiet while the tags are swept
  task automatic check_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!cpu_ack && !refill_req && !spr_ack) else begin
        $display("An output went high after reset before any stimulus");
        check_errs++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  task automatic cpu_access(input logic we, input word_t adr, input word_t dat,
                            input logic [3:0] bsel);
    int    waited;
    logic  refilled;
    logic  expect_hit;
    word_t exp;
    expect_hit = cached_valid[set_of(adr)] && (cached_base[set_of(adr)] == base_of(adr));
    exp        = model_read(adr);
    cpu_req    = '{req: 1'b1, we: we, adr: adr, dat: dat, bsel: bsel};
    waited     = 0;
    refilled   = 1'b0;
    do begin
      @(negedge clk);
      waited++;
      if (refill_req) begin
        refilled = 1'b1;
        assert (refill_adr == base_of(adr)) else begin
          $display("Error refill_adr_o expected %h actual %h", base_of(adr), refill_adr);
          check_errs++;
        end
      end
    end while (!cpu_ack && (waited < MAX_WAIT));
    if (!cpu_ack) begin
      $display("No cpu_ack_o within %0d cycles for address %h", MAX_WAIT, adr);
      check_errs++;
    end else if (we) begin
      // Writes finish in LOOKUP, hit or miss
      assert ((waited == 1) && !refilled) else begin
        $display("Write to %h was not acknowledged in LOOKUP without a refill", adr);
        check_errs++;
      end
      model_write(adr, dat, bsel);
    end else begin
      check_read_data(exp);
      if (expect_hit) begin
        assert ((waited == 1) && !refilled) else begin
          $display("Read hit at %h took %0d cycles or refilled", adr, waited);
          check_errs++;
        end
      end else begin
        assert (refilled) else begin
          $display("Read miss at %h never raised refill_req_o", adr);
          check_errs++;
        end
        cached_valid[set_of(adr)] = 1'b1;
        cached_base[set_of(adr)]  = base_of(adr);
      end
    end
    // Request held through the ack cycle, dropped the next one
    @(negedge clk);
    cpu_req.req = 1'b0;
  endtask

  task automatic spr_write(input logic [15:0] spr_adr, input word_t dat, input logic expect_ack);
    int   waited;
    logic acked;
    spr_bus = '{stb: 1'b1, we: 1'b1, adr: spr_adr, dat: dat};
    waited  = 0;
    acked   = 1'b0;
    // Ack comes in the same cycle as the clear and is read on the rising edge
    while (!acked && (waited < MAX_WAIT)) begin
      @(posedge clk);
      acked = spr_ack;
      waited++;
    end
    // Strobe drops in the cycle after the ack
    @(negedge clk);
    spr_bus.stb = 1'b0;
    spr_bus.we  = 1'b0;
    if (expect_ack) begin
      assert (acked) else begin
        $display("No spr_ack_o within %0d cycles for SPR %h", MAX_WAIT, spr_adr);
        check_errs++;
      end
      cached_valid[set_of(dat)] = 1'b0;
    end else begin
      assert (!acked) else begin
        $display("SPR write to unknown address %h was acknowledged", spr_adr);
        check_errs++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Refill responder
  ////////////////////////////////////////////////////////////

  // Words in order from the base, at most one gap between strobes
  always @(negedge clk) begin
    if (refill_req && (refill_cnt < WORDS)) begin
      gap_rng = lcg_next(gap_rng);
      if (gap_rng[31] && !gap_last) begin
        refill_bus.we = 1'b0;
        gap_last      = 1'b1;
      end else begin
        refill_bus.we  = 1'b1;
        refill_bus.dat = model_read(refill_adr + word_t'(4 * refill_cnt));
        refill_cnt++;
        gap_last       = 1'b0;
      end
    end else begin
      refill_bus.we = 1'b0;
      if (!refill_req) begin
        refill_cnt = 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    word_t rnd;
    word_t adr;
    int    asrt_errs;
    cpu_req    = '0;
    spr_bus    = '0;
    rst        = 1'b1;
    data_errs  = 0;
    check_errs = 0;
    for (int s = 0; s < SETS; s++) begin
      cached_valid[s] = 1'b0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // One set per cycle, then IDLE
    check_quiet(SETS + 2);

    // Miss, hit, partial write hit, merged read
    cpu_access(1'b0, 32'h0000_1040, '0, 4'h0);
    cpu_access(1'b0, 32'h0000_1044, '0, 4'h0);
    cpu_access(1'b1, 32'h0000_1048, 32'hcafe_f00d, 4'b0101);
    cpu_access(1'b0, 32'h0000_1048, '0, 4'h0);
    // Write miss, no allocate, then refill brings the store back
    cpu_access(1'b1, 32'h0000_2050, 32'h1234_5678, 4'b1100);
    cpu_access(1'b0, 32'h0000_2050, '0, 4'h0);
    // Invalidate and flush force a new refill
    spr_write(`DC_SPR_DCBIR, 32'h0000_1040, 1'b1);
    cpu_access(1'b0, 32'h0000_1044, '0, 4'h0);
    spr_write(`DC_SPR_DCBFR, 32'h0000_1044, 1'b1);
    spr_write(16'h3004, 32'h0000_2050, 1'b0);
    cpu_access(1'b0, 32'h0000_1048, '0, 4'h0);
    cpu_access(1'b0, 32'h0000_2054, '0, 4'h0);

    rnd = SEED;
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = lcg_next(rnd);
      adr = random_addr(rnd);
      case (rnd[25:24])
        2'd2: begin
          cpu_access(1'b1, adr, lcg_next(rnd), rnd[31:28]);
        end
        2'd3: begin
          if (rnd[27]) begin
            spr_write(rnd[26] ? `DC_SPR_DCBIR : `DC_SPR_DCBFR, adr, 1'b1);
          end else begin
            cpu_access(1'b0, adr, '0, 4'h0);
          end
        end
        default: begin
          cpu_access(1'b0, adr, '0, 4'h0);
        end
      endcase
    end

    repeat (2) @(negedge clk);
    asrt_errs = u_dut.u_asserts.fail_cnt;
    $display("Errors: %0d data, %0d behavior, %0d assertion", data_errs, check_errs, asrt_errs);
    if ((data_errs + check_errs + asrt_errs) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, run stopped after %0d cycles", cycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_top.f */
+incdir+.
dcache_pkg.sv
dcache_bus_pkg.sv
dcache_sdpram.sv
dcache_tag_arbiter.sv
dcache_inval.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
dcache_tb.sv

/* dcache_top.sv */
////////////////////////////////////////////////////////////
// Data cache top: controller, invalidate unit and tag RAM
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
  input  wire                              clk,
  input  wire                              rst,
  input  wire dcache_bus_pkg::dc_cpu_req_t cpu_i,
  output logic                             cpu_ack_o,
  output logic [`DC_ADDR_WIDTH-1:0]        cpu_dat_o,
  input  wire dcache_bus_pkg::dc_refill_t  refill_i,
  output logic                             refill_req_o,
  output logic [`DC_ADDR_WIDTH-1:0]        refill_adr_o,
  input  wire dcache_bus_pkg::dc_spr_t     spr_i,
  output logic                             spr_ack_o
);

  import dcache_pkg::*;

  // Tag RAM read path, controller only
  dc_set_t       tag_rindex;
  dc_tag_entry_t tag_rd;

  // Two tag writers and the grant back
  dc_tag_wr_t    ctrl_tag_wr;
  dc_tag_wr_t    inval_tag_wr;
  logic          inval_grant;

  dcache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cpu_i        (cpu_i),
    .cpu_ack_o    (cpu_ack_o),
    .cpu_dat_o    (cpu_dat_o),
    .refill_i     (refill_i),
    .refill_req_o (refill_req_o),
    .refill_adr_o (refill_adr_o),
    .tag_i        (tag_rd),
    .tag_rindex_o (tag_rindex),
    .tag_wr_o     (ctrl_tag_wr)
  );

  dcache_inval u_inval (
    .clk       (clk),
    .rst       (rst),
    .spr_i     (spr_i),
    .grant_i   (inval_grant),
    .wr_o      (inval_tag_wr),
    .spr_ack_o (spr_ack_o)
  );

  dcache_tag_arbiter u_arb (
    .clk           (clk),
    .rst           (rst),
    .rindex_i      (tag_rindex),
    .ctrl_wr_i     (ctrl_tag_wr),
    .inval_wr_i    (inval_tag_wr),
    .inval_grant_o (inval_grant),
    .tag_o         (tag_rd)
  );

endmodule

`default_nettype wire
